// ==== hdl/dhcp_macros.svh ====
`ifndef DHCP_MACROS_SVH
`define DHCP_MACROS_SVH

// Packet buffer geometry
`define DHCP_BUF_DEPTH          512
`define DHCP_BANK_BYTES         128  // Host window size per bank

// Host register map
`define DHCP_REG_CONTROL        0
`define DHCP_REG_BANK           1
`define DHCP_REG_LEN_LO         2
`define DHCP_REG_LEN_HI         3
`define DHCP_REG_IP0            4    // IP bytes at 4..7, low byte first
`define DHCP_REG_XID0           16   // XID bytes at 16..19, low byte first
`define DHCP_WINDOW_BIT         7    // Set means buffer window access

// Control and status bit positions
`define DHCP_CTL_ARM            0
`define DHCP_CTL_RX_ACTIVE      1
`define DHCP_CTL_PARTIAL        2
`define DHCP_CTL_TX             4
`define DHCP_CTL_REQUESTED      6
`define DHCP_CTL_IP_VALID       7

// Receive path
`define DHCP_PARTIAL_THRESHOLD  8    // Byte 8 in means XID is complete
`define DHCP_XID_FIRST          4

// UDP stack and fixed destination
`define DHCP_RESULT_ACCEPTED    2'b01
`define DHCP_BROADCAST_IP       32'hFFFF_FFFF
`define DHCP_SERVER_PORT        16'd67

`endif

// ==== hdl/dhcp_pkg.sv ====
`include "dhcp_macros.svh"

package dhcp_pkg;

    // One data byte on the UDP stream, host bus or buffer
    typedef logic [7:0] byte_t;

    // Byte address into the shared packet buffer
    typedef logic [$clog2(`DHCP_BUF_DEPTH)-1:0] buf_addr_t;

    // Transmit length minus one, same span as the buffer
    typedef logic [$clog2(`DHCP_BUF_DEPTH)-1:0] pkt_len_t;

    typedef logic [31:0] ip_addr_t;   // IPv4 address
    typedef logic [31:0] xid_t;       // DHCP transaction ID
    typedef logic [15:0] udp_port_t;  // UDP port number

    // Host port id, bit 7 selects the buffer window
    typedef logic [7:0] reg_addr_t;

    // Start result code from the UDP stack
    typedef logic [1:0] result_t;

endpackage

// ==== hdl/dhcp_ifs.sv ====
`timescale 1ns/10ps

// One requester port into the shared packet buffer
interface buffer_if;
    import dhcp_pkg::*;

    logic      req;    // Wants the memory this cycle
    buf_addr_t addr;
    byte_t     wdata;
    logic      we;     // Write, only honoured when granted
    byte_t     rdata;  // Byte at last cycle's granted address

    modport requester (output req, addr, wdata, we, input rdata);
    modport arbiter   (input req, addr, wdata, we, output rdata);
endinterface

// Receive control between the register window and the receiver
interface rx_ctrl_if;
    import dhcp_pkg::*;

    logic arm;           // One-cycle pulse from a control write
    logic armed;         // Next packet will be taken
    logic active;        // Packet being stored
    logic partial_done;  // Enough bytes in for the XID
    xid_t xid;

    modport host     (output arm, input armed, active, partial_done, xid);
    modport receiver (input arm, output armed, active, partial_done, xid);
endinterface

// ==== hdl/packet_buffer_arbiter.sv ====
`timescale 1ns/10ps
`include "dhcp_macros.svh"

module packet_buffer_arbiter (
    input logic      clk,
    buffer_if.arbiter rx,
    buffer_if.arbiter tx,
    buffer_if.arbiter host
);
    import dhcp_pkg::*;

    byte_t     mem [`DHCP_BUF_DEPTH];
    byte_t     rd_byte;
    buf_addr_t sel_addr;
    byte_t     sel_wdata;
    logic      sel_we;

    // Fixed priority, receiver first since incoming bytes cannot wait
    always_comb begin
        if (rx.req) begin
            sel_addr  = rx.addr;
            sel_wdata = rx.wdata;
            sel_we    = rx.we;
        end else if (tx.req) begin
            sel_addr  = tx.addr;
            sel_wdata = tx.wdata;
            sel_we    = tx.we;
        end else begin
            // Idle cycles still read at the host address,
            // so a held window address reads back without a strobe
            sel_addr  = host.addr;
            sel_wdata = host.wdata;
            sel_we    = host.req && host.we;
        end
    end

    // Single port, read-first
    always_ff @(posedge clk) begin
        if (sel_we) mem[sel_addr] <= sel_wdata;
        rd_byte <= mem[sel_addr];
    end

    // Same read byte goes to everybody, each knows whose address it was
    assign rx.rdata   = rd_byte;
    assign tx.rdata   = rd_byte;
    assign host.rdata = rd_byte;

endmodule

// ==== hdl/udp_receiver.sv ====
`timescale 1ns/10ps
`include "dhcp_macros.svh"

module udp_receiver (
    input  logic           clk,
    input  logic           reset,
    input  logic           udp_in_start,
    input  logic           udp_in_valid,
    input  logic           udp_in_last,
    input  dhcp_pkg::byte_t udp_in_data,
    input  logic           tx_active,
    rx_ctrl_if.receiver    ctrl,
    buffer_if.requester    pkt_buf
);
    import dhcp_pkg::*;

    logic      start_d;     // udp_in_start last cycle
    logic      start_edge;
    logic      take_pkt;    // First cycle of an accepted packet
    logic      rx_on;       // Bytes go to the buffer
    buf_addr_t rx_addr;
    buf_addr_t xid_sel;
    logic      xid_hit;

    assign start_edge = udp_in_start && !start_d;
    assign take_pkt   = ctrl.armed && start_edge && !tx_active;
    assign rx_on      = take_pkt || ctrl.active;

    // Offset into the XID field, bytes 4..7
    assign xid_sel = rx_addr - buf_addr_t'(`DHCP_XID_FIRST);
    assign xid_hit = (rx_addr >= `DHCP_XID_FIRST) && (rx_addr < `DHCP_XID_FIRST + 4);

    always_ff @(posedge clk) begin
        if (reset) begin
            start_d           <= 1'b0;
            ctrl.armed        <= 1'b0;
            ctrl.active       <= 1'b0;
            ctrl.partial_done <= 1'b0;
            rx_addr           <= '0;
        end else begin
            start_d <= udp_in_start;

            if (ctrl.arm) ctrl.armed <= 1'b1;
            else if (start_edge && !tx_active) ctrl.armed <= 1'b0;  // Any start disarms

            // A packet that starts and ends on the same byte is not kept
            if (take_pkt && !udp_in_last) ctrl.active <= 1'b1;
            else if (ctrl.active && udp_in_valid && udp_in_last) ctrl.active <= 1'b0;

            if (!ctrl.active || ctrl.armed) ctrl.partial_done <= 1'b0;  // Re-arm drops it
            else if (udp_in_valid && rx_addr == `DHCP_PARTIAL_THRESHOLD)
                ctrl.partial_done <= 1'b1;

            if (!rx_on) rx_addr <= '0;
            else if (udp_in_valid) rx_addr <= rx_addr + 1'b1;
        end
    end

    // Stored as received, byte 4 lands in the low byte
    always_ff @(posedge clk) begin
        if (rx_on && udp_in_valid && xid_hit) ctrl.xid[xid_sel[1:0]*8 +: 8] <= udp_in_data;
    end

    // Write-only requester, only asks when a byte is there
    assign pkt_buf.req   = rx_on && udp_in_valid;
    assign pkt_buf.we    = rx_on && udp_in_valid;
    assign pkt_buf.addr  = rx_addr;
    assign pkt_buf.wdata = udp_in_data;

endmodule

// ==== hdl/udp_transmitter.sv ====
`timescale 1ns/10ps
`include "dhcp_macros.svh"

module udp_transmitter (
    input  logic               clk,
    input  logic               reset,
    input  logic               tx_go,
    input  dhcp_pkg::pkt_len_t tx_length,
    input  logic               udp_out_ready,
    input  dhcp_pkg::result_t  udp_out_result,
    output logic               tx_active,
    output logic               udp_out_start,
    output logic               udp_out_valid,
    output logic               udp_out_last,
    output dhcp_pkg::byte_t    udp_out_data,
    output dhcp_pkg::buf_addr_t udp_out_length,
    buffer_if.requester        pkt_buf
);
    import dhcp_pkg::*;

    buf_addr_t tx_addr;
    logic      byte_done;   // Current byte taken by the stack

    assign byte_done = udp_out_valid && udp_out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_active     <= 1'b0;
            udp_out_start <= 1'b0;
            udp_out_valid <= 1'b0;
            tx_addr       <= '0;
        end else begin
            if (tx_go) tx_active <= 1'b1;
            else if (byte_done && tx_addr == tx_length) tx_active <= 1'b0;

            // Start request held until the stack takes it
            if (tx_go) udp_out_start <= 1'b1;
            else if (udp_out_start && udp_out_result == `DHCP_RESULT_ACCEPTED)
                udp_out_start <= 1'b0;

            // Valid drops for one cycle after each byte,
            // giving the buffer its cycle to fetch the next one
            if (!tx_active) udp_out_valid <= 1'b0;
            else if (!udp_out_valid) udp_out_valid <= 1'b1;
            else if (udp_out_ready) udp_out_valid <= 1'b0;

            if (!tx_active) tx_addr <= '0;
            else if (byte_done) tx_addr <= tx_addr + 1'b1;
        end
    end

    assign udp_out_last   = tx_active && (tx_addr == tx_length);
    assign udp_out_data   = pkt_buf.rdata;  // Re-read every cycle, stable while held
    assign udp_out_length = buf_addr_t'(tx_length + 1'b1);

    // Read-only requester for the whole transfer
    assign pkt_buf.req   = tx_active;
    assign pkt_buf.we    = 1'b0;
    assign pkt_buf.addr  = tx_addr;
    assign pkt_buf.wdata = '0;

endmodule

// ==== hdl/host_registers.sv ====
`timescale 1ns/10ps
`include "dhcp_macros.svh"

module host_registers (
    input  logic                clk,
    input  logic                reset,
    input  logic                do_dhcp,
    input  dhcp_pkg::reg_addr_t host_port_id,
    input  dhcp_pkg::byte_t     host_out_port,
    input  logic                host_write_strobe,
    input  logic                host_read_strobe,
    output dhcp_pkg::byte_t     host_in_port,
    input  logic                tx_active,
    output logic                tx_go,
    output dhcp_pkg::pkt_len_t  tx_length,
    output dhcp_pkg::ip_addr_t  ip_address,
    output logic                ip_address_valid,
    rx_ctrl_if.host             rx,
    buffer_if.requester         pkt_buf
);
    import dhcp_pkg::*;

    logic  win;        // Port id points into the buffer window
    logic  reg_wr;     // Write to a control register
    logic  ctl_wr;
    logic  requested;  // do_dhcp seen since reset
    logic [$clog2(`DHCP_BUF_DEPTH / `DHCP_BANK_BYTES)-1:0] bank;
    byte_t status;
    byte_t reg_rd;

    assign win    = host_port_id[`DHCP_WINDOW_BIT];
    assign reg_wr = host_write_strobe && !win;
    assign ctl_wr = reg_wr && host_port_id == `DHCP_REG_CONTROL;

    // Command bits are pulses straight off the write
    assign rx.arm = ctl_wr && host_out_port[`DHCP_CTL_ARM];
    assign tx_go  = ctl_wr && host_out_port[`DHCP_CTL_TX];

    always_ff @(posedge clk) begin
        if (reset) begin
            requested        <= 1'b0;
            ip_address_valid <= 1'b0;
            bank             <= '0;
            tx_length        <= '0;
            ip_address       <= '0;
        end else begin
            if (do_dhcp) requested <= 1'b1;  // Level latched, only reset clears
            if (ctl_wr && host_out_port[`DHCP_CTL_IP_VALID])
                ip_address_valid <= !ip_address_valid;  // Toggle, not set
            if (reg_wr && host_port_id == `DHCP_REG_BANK)
                bank <= host_out_port[$bits(bank)-1:0];
            if (reg_wr && host_port_id == `DHCP_REG_LEN_LO) tx_length[7:0] <= host_out_port;
            if (reg_wr && host_port_id == `DHCP_REG_LEN_HI) tx_length[8] <= host_out_port[0];
            // IP bytes at 4..7
            if (reg_wr && (host_port_id & 8'hFC) == `DHCP_REG_IP0)
                ip_address[host_port_id[1:0]*8 +: 8] <= host_out_port;
        end
    end

    always_comb begin
        status                      = '0;
        status[`DHCP_CTL_ARM]       = rx.armed;
        status[`DHCP_CTL_RX_ACTIVE] = rx.active;
        status[`DHCP_CTL_PARTIAL]   = rx.partial_done;
        status[`DHCP_CTL_TX]        = tx_active;
        status[`DHCP_CTL_REQUESTED] = requested;
        status[`DHCP_CTL_IP_VALID]  = ip_address_valid;
    end

    // Register read-back, unmapped ids read zero
    always_comb begin
        reg_rd = '0;
        if (host_port_id == `DHCP_REG_CONTROL) reg_rd = status;
        else if (host_port_id == `DHCP_REG_BANK) reg_rd = byte_t'(bank);
        else if (host_port_id == `DHCP_REG_LEN_LO) reg_rd = tx_length[7:0];
        else if (host_port_id == `DHCP_REG_LEN_HI) reg_rd = byte_t'(tx_length[8]);
        else if ((host_port_id & 8'hFC) == `DHCP_REG_IP0)
            reg_rd = ip_address[host_port_id[1:0]*8 +: 8];
        else if ((host_port_id & 8'hFC) == `DHCP_REG_XID0)
            reg_rd = rx.xid[host_port_id[1:0]*8 +: 8];
    end

    // Window reads show last cycle's address, receive and transmit win the memory
    assign host_in_port = win ? pkt_buf.rdata : reg_rd;

    assign pkt_buf.req   = win && (host_read_strobe || host_write_strobe);
    assign pkt_buf.we    = host_write_strobe;
    assign pkt_buf.addr  = {bank, host_port_id[$clog2(`DHCP_BANK_BYTES)-1:0]};
    assign pkt_buf.wdata = host_out_port;

endmodule

// ==== hdl/dhcp_offload_top.sv ====
`timescale 1ns/10ps
`include "dhcp_macros.svh"

module dhcp_offload_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 do_dhcp,
    input  logic                 udp_in_start,
    input  logic                 udp_in_valid,
    input  logic                 udp_in_last,
    input  logic                 udp_out_ready,
    input  dhcp_pkg::byte_t      udp_in_data,
    input  dhcp_pkg::result_t    udp_out_result,
    input  dhcp_pkg::reg_addr_t  host_port_id,
    input  dhcp_pkg::byte_t      host_out_port,
    input  logic                 host_write_strobe,
    input  logic                 host_read_strobe,
    output dhcp_pkg::byte_t      host_in_port,
    output dhcp_pkg::byte_t      udp_out_data,
    output logic                 udp_out_valid,
    output logic                 udp_out_last,
    output logic                 udp_out_start,
    output dhcp_pkg::buf_addr_t  udp_out_length,
    output dhcp_pkg::ip_addr_t   udp_out_dst_ip_addr,
    output dhcp_pkg::udp_port_t  udp_out_dst_port,
    output dhcp_pkg::ip_addr_t   ip_address,
    output logic                 ip_address_valid
);
    import dhcp_pkg::*;

    logic     tx_active;  // Read by the register window and the receiver
    logic     tx_go;
    pkt_len_t tx_length;

    buffer_if  rx_buf ();
    buffer_if  tx_buf ();
    buffer_if  host_buf ();
    rx_ctrl_if rx_ctrl ();

    packet_buffer_arbiter arb_i (
        .clk  (clk),
        .rx   (rx_buf),
        .tx   (tx_buf),
        .host (host_buf)
    );

    udp_receiver rx_i (
        .clk          (clk),
        .reset        (reset),
        .udp_in_start (udp_in_start),
        .udp_in_valid (udp_in_valid),
        .udp_in_last  (udp_in_last),
        .udp_in_data  (udp_in_data),
        .tx_active    (tx_active),
        .ctrl         (rx_ctrl),
        .pkt_buf      (rx_buf)
    );

    udp_transmitter tx_i (
        .clk            (clk),
        .reset          (reset),
        .tx_go          (tx_go),
        .tx_length      (tx_length),
        .udp_out_ready  (udp_out_ready),
        .udp_out_result (udp_out_result),
        .tx_active      (tx_active),
        .udp_out_start  (udp_out_start),
        .udp_out_valid  (udp_out_valid),
        .udp_out_last   (udp_out_last),
        .udp_out_data   (udp_out_data),
        .udp_out_length (udp_out_length),
        .pkt_buf        (tx_buf)
    );

    host_registers regs_i (
        .clk               (clk),
        .reset             (reset),
        .do_dhcp           (do_dhcp),
        .host_port_id      (host_port_id),
        .host_out_port     (host_out_port),
        .host_write_strobe (host_write_strobe),
        .host_read_strobe  (host_read_strobe),
        .host_in_port      (host_in_port),
        .tx_active         (tx_active),
        .tx_go             (tx_go),
        .tx_length         (tx_length),
        .ip_address        (ip_address),
        .ip_address_valid  (ip_address_valid),
        .rx                (rx_ctrl),
        .pkt_buf           (host_buf)
    );

    // Client side of DHCP always talks to any server
    assign udp_out_dst_ip_addr = `DHCP_BROADCAST_IP;
    assign udp_out_dst_port    = `DHCP_SERVER_PORT;

endmodule

// ==== verification/dhcp_offload_assertions.sv ====
`timescale 1ns/10ps
`include "dhcp_macros.svh"

module dhcp_offload_assertions (
    input logic                clk,
    input logic                reset,
    input logic                udp_out_ready,
    input dhcp_pkg::result_t   udp_out_result,
    input logic                udp_out_start,
    input logic                udp_out_valid,
    input logic                udp_out_last,
    input dhcp_pkg::byte_t     udp_out_data,
    input dhcp_pkg::ip_addr_t  udp_out_dst_ip_addr,
    input dhcp_pkg::udp_port_t udp_out_dst_port,
    input logic                ip_address_valid,
    input logic                tx_active,
    input logic                armed,
    input logic                rx_active
);
    import dhcp_pkg::*;

    int unsigned fail_count = 0;  // Tally for the closing summary

    // Everything idle in the cycle after a reset cycle
    reset_idle: assert property (@(posedge clk)
        reset |=> !(udp_out_start || udp_out_valid || udp_out_last || ip_address_valid
                    || tx_active || armed || rx_active))
        else begin
            $error("control output active after reset");
            fail_count++;
        end

    // Back-pressure holds the byte in place
    tx_hold: assert property (@(posedge clk) disable iff (reset)
        udp_out_valid && !udp_out_ready
            |=> udp_out_valid && $stable(udp_out_data) && $stable(udp_out_last))
        else begin
            $error("transmit byte changed under back-pressure");
            fail_count++;
        end

    start_held: assert property (@(posedge clk) disable iff (reset)
        udp_out_start && udp_out_result != `DHCP_RESULT_ACCEPTED |=> udp_out_start)
        else begin
            $error("start request dropped before accept");
            fail_count++;
        end

    // Limited broadcast address and the DHCP server port
    fixed_dest: assert property (@(posedge clk)
        udp_out_dst_ip_addr == 32'hFFFF_FFFF && udp_out_dst_port == 16'd67)
        else begin
            $error("destination is not broadcast port 67");
            fail_count++;
        end

endmodule

bind dhcp_offload_top dhcp_offload_assertions checks_i (
    .clk                 (clk),
    .reset               (reset),
    .udp_out_ready       (udp_out_ready),
    .udp_out_result      (udp_out_result),
    .udp_out_start       (udp_out_start),
    .udp_out_valid       (udp_out_valid),
    .udp_out_last        (udp_out_last),
    .udp_out_data        (udp_out_data),
    .udp_out_dst_ip_addr (udp_out_dst_ip_addr),
    .udp_out_dst_port    (udp_out_dst_port),
    .ip_address_valid    (ip_address_valid),
    .tx_active           (tx_active),
    .armed               (rx_ctrl.armed),
    .rx_active           (rx_ctrl.active)
);

// ==== verification/dhcp_offload_tb.sv ====
`timescale 1ns/10ps
`include "dhcp_macros.svh"

module dhcp_offload_tb;
    import dhcp_pkg::*;

    localparam int max_wait = 2000;  // Cycles allowed for any single wait

    logic      clk;
    logic      reset;
    logic      do_dhcp;
    logic      udp_in_start;
    logic      udp_in_valid;
    logic      udp_in_last;
    logic      udp_out_ready;
    byte_t     udp_in_data;
    result_t   udp_out_result;
    reg_addr_t host_port_id;
    byte_t     host_out_port;
    logic      host_write_strobe;
    logic      host_read_strobe;
    byte_t     host_in_port;
    byte_t     udp_out_data;
    logic      udp_out_valid;
    logic      udp_out_last;
    logic      udp_out_start;
    buf_addr_t udp_out_length;
    ip_addr_t  udp_out_dst_ip_addr;
    udp_port_t udp_out_dst_port;
    ip_addr_t  ip_address;
    logic      ip_address_valid;

    byte_t     buf_model [`DHCP_BUF_DEPTH];  // Expected buffer contents
    byte_t     pkt_q [$];                    // Packet being sent on the UDP input
    xid_t      xid_model;
    ip_addr_t  ip_model;
    int        errors = 0;
    int        timeouts = 0;

    dhcp_offload_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // Drive point, shortly after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic host_write(input reg_addr_t id, input byte_t data);
        next_cycle();
        host_port_id      = id;
        host_out_port     = data;
        host_write_strobe = 1'b1;
        next_cycle();                 // Written at the edge just passed
        host_write_strobe = 1'b0;
    endtask

    task automatic read_register(input reg_addr_t id, output byte_t val);
        next_cycle();
        host_port_id     = id;
        host_read_strobe = 1'b1;
        @(negedge clk);               // Combinational read, settled mid cycle
        val = host_in_port;
        next_cycle();
        host_read_strobe = 1'b0;
    endtask

    task automatic write_window(input buf_addr_t addr, input byte_t data);
        host_write(`DHCP_REG_BANK, byte_t'(addr >> 7));
        host_write(reg_addr_t'(8'h80 | addr[6:0]), data);
    endtask

    task automatic read_window(input buf_addr_t addr, output byte_t val);
        host_write(`DHCP_REG_BANK, byte_t'(addr >> 7));
        next_cycle();
        host_port_id     = reg_addr_t'(8'h80 | addr[6:0]);
        host_read_strobe = 1'b1;
        @(posedge clk);               // Memory read at this edge
        @(negedge clk);
        val = host_in_port;
        next_cycle();
        host_read_strobe = 1'b0;
    endtask

    task automatic verify_buffer();
        byte_t v;
        for (int a = 0; a < `DHCP_BUF_DEPTH; a++) begin
            read_window(buf_addr_t'(a), v);
            check_value(v, buf_model[a], $sformatf("buffer byte %0d", a));
        end
    endtask

    task automatic verify_xid();
        byte_t v;
        for (int k = 0; k < 4; k++) begin
            read_register(reg_addr_t'(`DHCP_REG_XID0 + k), v);
            check_value(v, xid_model[k*8 +: 8], $sformatf("xid byte %0d", k));
        end
    endtask

    // Streams pkt_q, optionally pausing after byte 8 to look at the status
    task automatic send_packet(input bit check_partial);
        byte_t status;
        for (int i = 0; i < pkt_q.size(); i++) begin
            next_cycle();
            udp_in_start = 1'b1;
            udp_in_valid = 1'b1;
            udp_in_data  = pkt_q[i];
            udp_in_last  = (i == pkt_q.size() - 1);
            if (check_partial && i == `DHCP_PARTIAL_THRESHOLD) begin
                next_cycle();
                udp_in_valid = 1'b0;  // Hold off the source
                read_register(`DHCP_REG_CONTROL, status);
                check_value(status[`DHCP_CTL_PARTIAL], 1'b1, "partial bit in pause");
                check_value(status[`DHCP_CTL_ARM], 1'b0, "armed after start edge");
            end
        end
        next_cycle();
        udp_in_valid = 1'b0;
        udp_in_last  = 1'b0;
        udp_in_start = 1'b0;
    endtask

    // Stack side, takes the start request after a short delay
    task automatic accept_start();
        repeat (3) begin
            next_cycle();
            check_value(udp_out_start, 1'b1, "start held before accept");
        end
        udp_out_result = `DHCP_RESULT_ACCEPTED;
        next_cycle();
        udp_out_result = '0;
        check_value(udp_out_start, 1'b0, "start after accept");
    endtask

    task automatic collect_tx_bytes(input int n);
        int count;
        int waited;
        count  = 0;
        waited = 0;
        while (count < n && waited < max_wait) begin
            @(negedge clk);           // Ready and outputs both settled here
            if (udp_out_valid && udp_out_ready) begin
                check_value(udp_out_data, buf_model[count], $sformatf("tx byte %0d", count));
                check_value(udp_out_last, count == n - 1, $sformatf("tx last on %0d", count));
                count++;
            end
            next_cycle();
            udp_out_ready = ($urandom % 4) != 0;  // Random back-pressure
            waited++;
        end
        udp_out_ready = 1'b0;
        if (count < n) begin
            timeouts++;
            $display("Timeout: only %0d of %0d transmit bytes arrived", count, n);
        end
    endtask

    initial begin
        byte_t status;
        int    n;
        int    waited;
        void'($urandom(32'hb35d7676));
        reset             = 1'b1;
        do_dhcp           = 1'b0;
        udp_in_start      = 1'b0;
        udp_in_valid      = 1'b0;
        udp_in_last       = 1'b0;
        udp_in_data       = '0;
        udp_out_ready     = 1'b0;
        udp_out_result    = '0;
        host_port_id      = '0;
        host_out_port     = '0;
        host_write_strobe = 1'b0;
        host_read_strobe  = 1'b0;
        repeat (10) next_cycle();
        reset = 1'b0;

        // All four banks through the window
        for (int a = 0; a < `DHCP_BUF_DEPTH; a++) begin
            buf_model[a] = byte_t'($urandom);
            write_window(buf_addr_t'(a), buf_model[a]);
        end
        verify_buffer();

        // Armed receive
        pkt_q.delete();
        for (int i = 0; i < 40; i++) pkt_q.push_back(byte_t'($urandom));
        host_write(`DHCP_REG_CONTROL, 8'h01 << `DHCP_CTL_ARM);
        read_register(`DHCP_REG_CONTROL, status);
        check_value(status[`DHCP_CTL_ARM], 1'b1, "armed after arm write");
        send_packet(1'b1);
        foreach (pkt_q[i]) buf_model[i] = pkt_q[i];
        xid_model = {pkt_q[7], pkt_q[6], pkt_q[5], pkt_q[4]};  // Byte 4 lowest
        verify_buffer();
        verify_xid();
        read_register(`DHCP_REG_CONTROL, status);
        check_value(status[`DHCP_CTL_PARTIAL], 1'b0, "partial bit after packet");

        // Not armed, must be ignored
        pkt_q.delete();
        for (int i = 0; i < 40; i++) pkt_q.push_back(byte_t'($urandom));
        send_packet(1'b0);
        verify_buffer();
        verify_xid();

        // Transmit N bytes from the buffer
        n = 20 + ($urandom % 40);
        host_write(`DHCP_REG_LEN_LO, byte_t'(n - 1));
        host_write(`DHCP_REG_LEN_HI, byte_t'((n - 1) >> 8));
        host_write(`DHCP_REG_CONTROL, 8'h01 << `DHCP_CTL_TX);
        check_value(udp_out_start, 1'b1, "start after tx write");
        check_value(udp_out_length, n, "udp_out_length");
        fork
            accept_start();
            collect_tx_bytes(n);
        join
        waited = 0;
        do begin
            read_register(`DHCP_REG_CONTROL, status);
            waited++;
        end while (status[`DHCP_CTL_TX] && waited < 50);
        if (status[`DHCP_CTL_TX]) begin
            timeouts++;
            $display("Timeout: transmitter still active after the last byte");
        end

        // IP address, valid toggle and request latch
        ip_model = $urandom;
        for (int k = 0; k < 4; k++)
            host_write(reg_addr_t'(`DHCP_REG_IP0 + k), ip_model[k*8 +: 8]);
        check_value(ip_address, ip_model, "ip_address");
        check_value(ip_address_valid, 1'b0, "ip valid before toggle");
        host_write(`DHCP_REG_CONTROL, 8'h01 << `DHCP_CTL_IP_VALID);
        check_value(ip_address_valid, 1'b1, "ip valid after first toggle");
        host_write(`DHCP_REG_CONTROL, 8'h01 << `DHCP_CTL_IP_VALID);
        check_value(ip_address_valid, 1'b0, "ip valid after second toggle");
        read_register(`DHCP_REG_CONTROL, status);
        check_value(status[`DHCP_CTL_REQUESTED], 1'b0, "requested before do_dhcp");
        next_cycle();
        do_dhcp = 1'b1;
        next_cycle();
        do_dhcp = 1'b0;
        read_register(`DHCP_REG_CONTROL, status);
        check_value(status[`DHCP_CTL_REQUESTED], 1'b1, "requested after do_dhcp");

        repeat (5) next_cycle();
        $display("Summary: %0d check errors, %0d timeouts, %0d assertion failures",
                 errors, timeouts, dut_i.checks_i.fail_count);
        if (errors == 0 && timeouts == 0 && dut_i.checks_i.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/dhcp_pkg.sv
hdl/dhcp_ifs.sv
hdl/packet_buffer_arbiter.sv
hdl/udp_receiver.sv
hdl/udp_transmitter.sv
hdl/host_registers.sv
hdl/dhcp_offload_top.sv
verification/dhcp_offload_assertions.sv
verification/dhcp_offload_tb.sv

// ==== Bender.yml ====
package:
  name: dhcp_offload

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/dhcp_pkg.sv
      - hdl/dhcp_ifs.sv
      - hdl/packet_buffer_arbiter.sv
      - hdl/udp_receiver.sv
      - hdl/udp_transmitter.sv
      - hdl/host_registers.sv
      - hdl/dhcp_offload_top.sv
  - target: test
    files:
      - verification/dhcp_offload_assertions.sv
      - verification/dhcp_offload_tb.sv
